//--- verilog/fma_cfg.svh
// fma configuration: binary32 field widths, exponent bias and pipeline sizes
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// binary32 exponent field
`define FMA_EXP_W     8

// fraction plus hidden bit
`define FMA_MAN_W     24

`define FMA_BIAS      127

// signed adder window, product plus addend headroom
`define FMA_SUM_W     76

// radix-4 booth rows for a 24-bit multiplier
`define FMA_PP_N      13

// one register bank per stage
`define FMA_LATENCY   5

`endif

//--- verilog/fma_pkg.sv
// fma_pkg: binary32 operand type and the payload types passed between pipeline stages
`default_nettype none
`include "fma_cfg.svh"

package fma_pkg;

   // biased exponent with room for products and normalization offsets
   typedef logic signed [`FMA_EXP_W+1:0] exp_t;

   typedef struct packed {
      logic                  sign;
      logic [`FMA_EXP_W-1:0] exp;
      logic [`FMA_MAN_W-2:0] frac;
   } fp32_t;

   typedef enum logic {
      ALIGN_LEFT  = 1'b0,  // addend above the product
      ALIGN_RIGHT = 1'b1
   } align_dir_e;

   typedef enum logic {
      MODE_ADDEND = 1'b0,  // product only reaches sticky
      MODE_SUM    = 1'b1
   } add_mode_e;

   typedef struct packed {
      logic [`FMA_MAN_W-1:0] man_a;
      logic [`FMA_MAN_W-1:0] man_b;
      logic [`FMA_MAN_W-1:0] man_c;
      logic                  prod_sign;
      logic                  eff_sub;
      exp_t                  prod_exp;
      logic [`FMA_EXP_W:0]   shift;      // magnitude of exp_c - prod_exp
      align_dir_e            dir;
      logic                  prod_zero;
   } unpack_t;

   typedef struct packed {
      logic [2*`FMA_MAN_W-1:0] prod;
      logic [`FMA_SUM_W-1:0]   addend;   // sticky already folded into bit 0
      exp_t                    ref_exp;  // exponent of window bit 47
      add_mode_e               mode;
      logic                    prod_sign;
      logic                    c_sign;
   } prod_t;

   typedef struct packed {
      logic [`FMA_SUM_W-1:0] mag;
      logic                  sign;
      exp_t                  ref_exp;
      logic                  zero;
   } sum_t;

   typedef struct packed {
      logic [`FMA_MAN_W+2:0] mant;       // 24 bits, guard, round, sticky
      exp_t                  exp;
      logic                  sign;
      logic                  zero;
   } norm_t;

endpackage

`default_nettype wire

//--- verilog/booth_pp_gen.sv
// booth_pp_gen: radix-4 booth partial product for one three-bit multiplier window
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module booth_pp_gen (
   input  logic [`FMA_MAN_W:0]     multiplicand,
   input  logic [2:0]              window,
   output logic [2*`FMA_MAN_W+1:0] partial_product
);

   logic [2*`FMA_MAN_W+1:0] one_x;
   logic [2*`FMA_MAN_W+1:0] two_x;
   logic [2*`FMA_MAN_W+1:0] mag;
   logic                    neg;

   assign one_x = {{(`FMA_MAN_W+1){1'b0}}, multiplicand};
   assign two_x = one_x << 1;

   always_comb begin
      case (window)
         3'b001, 3'b010: mag = one_x;  // +1
         3'b101, 3'b110: mag = one_x;  // -1
         3'b011, 3'b100: mag = two_x;  // +2 / -2
         default:        mag = '0;     // 000 and 111
      endcase
      neg = window[2] && (window != 3'b111);
   end

   // sign extended over the full row, positional shift left to the caller
   assign partial_product = neg ? (~mag + 1'b1) : mag;

endmodule

`default_nettype wire

//--- verilog/fma_unpack.sv
// fma_unpack: stage 1, operand split, product exponent and addend alignment shift
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_unpack (
   input  logic             clk,
   input  logic             reset,
   input  fma_pkg::fp32_t   a,
   input  fma_pkg::fp32_t   b,
   input  fma_pkg::fp32_t   c,
   output fma_pkg::unpack_t stage_out
);

   fma_pkg::unpack_t nxt;
   fma_pkg::exp_t    exp_diff;   // exp_c minus product exponent
   fma_pkg::exp_t    exp_mag;

   always_comb begin
      nxt = '0;

      // hidden bit only for nonzero exponents
      nxt.man_a = {a.exp != '0, a.frac};
      nxt.man_b = {b.exp != '0, b.frac};
      nxt.man_c = {c.exp != '0, c.frac};

      nxt.prod_sign = a.sign ^ b.sign;
      nxt.eff_sub   = a.sign ^ b.sign ^ c.sign;
      nxt.prod_zero = (a.exp == '0) || (b.exp == '0);

      nxt.prod_exp = fma_pkg::exp_t'({2'b00, a.exp})
                     + fma_pkg::exp_t'({2'b00, b.exp})
                     - fma_pkg::exp_t'(`FMA_BIAS);

      exp_diff = fma_pkg::exp_t'({2'b00, c.exp}) - nxt.prod_exp;

      // negative difference means c sits below the product
      if (exp_diff < 0) begin
         nxt.dir = fma_pkg::ALIGN_RIGHT;
         exp_mag = -exp_diff;
      end else begin
         nxt.dir = fma_pkg::ALIGN_LEFT;
         exp_mag = exp_diff;
      end
      nxt.shift = exp_mag[`FMA_EXP_W:0];
   end

   always_ff @(posedge clk) begin
      if (reset)
         stage_out <= '0;
      else
         stage_out <= nxt;
   end

   // direction feeds the stage 2 mux select
   a_dir_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(stage_out.dir));

endmodule

`default_nettype wire

//--- verilog/fma_mul_align.sv
// fma_mul_align: stage 2, booth/carry-save mantissa product and addend alignment with sticky
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_mul_align (
   input  logic             clk,
   input  logic             reset,
   input  fma_pkg::unpack_t stage_in,
   output fma_pkg::prod_t   stage_out
);

   localparam int MAN_W    = `FMA_MAN_W;
   localparam int SUM_W    = `FMA_SUM_W;
   localparam int PROD_W   = 2*MAN_W;
   localparam int PP_W     = 2*MAN_W + 2;
   localparam int LEFT_MAX = SUM_W - PROD_W - 2;  // 26, largest in-window left shift

   logic [PP_W-1:0]    pp [`FMA_PP_N];
   logic [MAN_W+2:0]   mul_ext;
   logic [PP_W-1:0]    lv1 [9];
   logic [PP_W-1:0]    lv2 [6];
   logic [PP_W-1:0]    lv3 [4];
   logic [PP_W-1:0]    lv4 [3];
   logic [PP_W-1:0]    lv5 [2];
   logic [PP_W-1:0]    prod_full;
   logic [PROD_W-1:0]  product;
   logic [SUM_W-1:0]   ext_c;
   logic [SUM_W-1:0]   right_c;
   logic [SUM_W-1:0]   lost_mask;
   logic               c_sticky;
   logic               addend_only;
   fma_pkg::exp_t      shift_s;
   fma_pkg::exp_t      exp_c;
   fma_pkg::prod_t     nxt;

   // 3:2 compressor over a whole row, carries moved up one place
   function automatic logic [2*PP_W-1:0] csa32(input logic [PP_W-1:0] x,
                                               input logic [PP_W-1:0] y,
                                               input logic [PP_W-1:0] z);
      logic [PP_W-1:0] carry;
      carry = (x & y) | (y & z) | (x & z);
      return {carry << 1, x ^ y ^ z};
   endfunction

   assign mul_ext = {2'b00, stage_in.man_b, 1'b0};  // implicit zero below bit 0

   genvar gi;
   generate
      for (gi = 0; gi < `FMA_PP_N; gi++) begin : g_pp
         logic [PP_W-1:0] row;
         booth_pp_gen i_booth (
            .multiplicand    ({1'b0, stage_in.man_a}),
            .window          (mul_ext[2*gi+2 -: 3]),
            .partial_product (row)
         );
         assign pp[gi] = row << (2*gi);
      end
   endgenerate

   // 13 -> 9 -> 6 -> 4 -> 3 -> 2
   always_comb begin
      for (int k = 0; k < 4; k++)
         {lv1[2*k+1], lv1[2*k]} = csa32(pp[3*k], pp[3*k+1], pp[3*k+2]);
      lv1[8] = pp[`FMA_PP_N-1];
      for (int k = 0; k < 3; k++)
         {lv2[2*k+1], lv2[2*k]} = csa32(lv1[3*k], lv1[3*k+1], lv1[3*k+2]);
      for (int k = 0; k < 2; k++)
         {lv3[2*k+1], lv3[2*k]} = csa32(lv2[3*k], lv2[3*k+1], lv2[3*k+2]);
      {lv4[1], lv4[0]} = csa32(lv3[0], lv3[1], lv3[2]);
      lv4[2] = lv3[3];
      {lv5[1], lv5[0]} = csa32(lv4[0], lv4[1], lv4[2]);
   end

   assign prod_full = lv5[0] + lv5[1];
   assign product   = prod_full[PROD_W-1:0];

   always_comb begin
      ext_c     = SUM_W'(stage_in.man_c) << MAN_W;  // units bit at 47, level with product
      right_c   = ext_c >> stage_in.shift;
      lost_mask = ~({SUM_W{1'b1}} << stage_in.shift);
      c_sticky  = |(ext_c & lost_mask);
      shift_s   = fma_pkg::exp_t'({1'b0, stage_in.shift});
      if (stage_in.dir == fma_pkg::ALIGN_LEFT)
         exp_c = stage_in.prod_exp + shift_s;
      else
         exp_c = stage_in.prod_exp - shift_s;

      // zero product or c far above it
      addend_only = stage_in.prod_zero
                    || (stage_in.dir == fma_pkg::ALIGN_LEFT
                        && stage_in.shift > LEFT_MAX
                        && stage_in.man_c[MAN_W-1]);

      nxt           = '0;
      nxt.prod_sign = stage_in.prod_sign;
      nxt.c_sign    = stage_in.prod_sign ^ stage_in.eff_sub;
      if (addend_only) begin
         nxt.mode    = fma_pkg::MODE_ADDEND;
         nxt.prod    = PROD_W'(|product);
         nxt.addend  = ext_c;
         nxt.ref_exp = exp_c;
      end else begin
         nxt.mode    = fma_pkg::MODE_SUM;
         nxt.prod    = product;
         nxt.ref_exp = stage_in.prod_exp;
         if (stage_in.dir == fma_pkg::ALIGN_LEFT)
            nxt.addend = ext_c << stage_in.shift;
         else
            nxt.addend = right_c | SUM_W'(c_sticky);
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         stage_out <= '0;
      else
         stage_out <= nxt;
   end

endmodule

`default_nettype wire

//--- verilog/fma_add.sv
// fma_add: stage 3, signed window add of product and addend with magnitude and sign recovery
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_add (
   input  logic           clk,
   input  logic           reset,
   input  fma_pkg::prod_t stage_in,
   output fma_pkg::sum_t  stage_out
);

   localparam int SUM_W = `FMA_SUM_W;

   logic [SUM_W-1:0] prod_win;
   logic [SUM_W-1:0] raw;
   logic             eff_sub;
   logic             neg;
   fma_pkg::sum_t    nxt;

   always_comb begin
      eff_sub = stage_in.prod_sign ^ stage_in.c_sign;

      if (stage_in.mode == fma_pkg::MODE_SUM)
         prod_win = SUM_W'({stage_in.prod, 1'b0});  // units bit at 47
      else
         prod_win = SUM_W'(stage_in.prod[0]);       // sticky under every addend bit

      if (eff_sub)
         raw = prod_win + ~stage_in.addend + 1'b1;
      else
         raw = prod_win + stage_in.addend;

      // top bit never carries a magnitude, so it is the sign
      neg = raw[SUM_W-1];

      nxt         = '0;
      nxt.mag     = neg ? -raw : raw;
      nxt.zero    = (raw == '0);
      nxt.ref_exp = stage_in.ref_exp;
      if (nxt.zero)
         nxt.sign = stage_in.prod_sign & stage_in.c_sign;  // -0 only from two negatives
      else
         nxt.sign = stage_in.prod_sign ^ neg;
   end

   always_ff @(posedge clk) begin
      if (reset)
         stage_out <= '0;
      else
         stage_out <= nxt;
   end

endmodule

`default_nettype wire

//--- verilog/fma_normalize.sv
// fma_normalize: stage 4, leading-zero count, normalizing shift and exponent adjust
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_normalize (
   input  logic          clk,
   input  logic          reset,
   input  fma_pkg::sum_t stage_in,
   output fma_pkg::norm_t stage_out
);

   localparam int SUM_W   = `FMA_SUM_W;
   localparam int KEEP    = `FMA_MAN_W + 2;        // mantissa, guard, round
   localparam int WIN_POS = SUM_W - 2*`FMA_MAN_W;  // bit 75 sits 28 above bit 47

   logic [6:0]       lzc;
   logic [SUM_W-1:0] shifted;
   fma_pkg::norm_t   nxt;

   // last hit from the bottom is the leading one
   function automatic logic [6:0] lead_zeros(input logic [SUM_W-1:0] x);
      logic [6:0] cnt;
      cnt = 7'(SUM_W);
      for (int i = 0; i < SUM_W; i++)
         if (x[i])
            cnt = 7'(SUM_W - 1 - i);
      return cnt;
   endfunction

   always_comb begin
      lzc     = lead_zeros(stage_in.mag);
      shifted = stage_in.mag << lzc;

      nxt      = '0;
      nxt.mant = {shifted[SUM_W-1 -: KEEP], |shifted[SUM_W-KEEP-1:0]};
      nxt.exp  = stage_in.ref_exp + fma_pkg::exp_t'(WIN_POS)
                 - fma_pkg::exp_t'({3'b000, lzc});
      nxt.sign = stage_in.sign;
      nxt.zero = stage_in.zero;
   end

   always_ff @(posedge clk) begin
      if (reset)
         stage_out <= '0;
      else
         stage_out <= nxt;
   end

   // a nonzero sum must come out with the leading one on top
   a_norm_msb: assert property (@(posedge clk) disable iff (reset)
      (stage_in.mag != '0) |=> stage_out.mant[KEEP]);

endmodule

`default_nettype wire

//--- verilog/fma_round.sv
// fma_round: stage 5, round to nearest even on guard/round/sticky and pack into binary32
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_round (
   input  logic           clk,
   input  logic           reset,
   input  fma_pkg::norm_t stage_in,
   output fma_pkg::fp32_t result
);

   localparam int MAN_W = `FMA_MAN_W;

   logic [MAN_W-1:0] keep;
   logic [MAN_W:0]   rounded;   // extra bit for the carry out
   logic [MAN_W-1:0] mant_n;
   logic             guard;
   logic             rnd;
   logic             sticky;
   logic             round_up;
   logic             is_zero;
   fma_pkg::exp_t    exp_fin;
   fma_pkg::fp32_t   nxt;

   always_comb begin
      keep   = stage_in.mant[MAN_W+2:3];
      guard  = stage_in.mant[2];
      rnd    = stage_in.mant[1];
      sticky = stage_in.mant[0];

      // above half, or exactly half with an odd lsb
      round_up = guard && (rnd || sticky || keep[0]);
      rounded  = {1'b0, keep} + (MAN_W+1)'(round_up);

      // carry out leaves 1.000..., shift back and bump the exponent
      mant_n  = rounded[MAN_W] ? rounded[MAN_W:1] : rounded[MAN_W-1:0];
      exp_fin = stage_in.exp + fma_pkg::exp_t'({1'b0, rounded[MAN_W]});

      // empty pipe slots also arrive without a leading one
      is_zero = stage_in.zero || !stage_in.mant[MAN_W+2];

      nxt = '0;
      nxt.sign = stage_in.sign;
      if (!is_zero) begin
         nxt.exp  = exp_fin[`FMA_EXP_W-1:0];
         nxt.frac = mant_n[MAN_W-2:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         result <= '0;
      else
         result <= nxt;
   end

   // nonzero results stay inside the normal range
   a_exp_normal: assert property (@(posedge clk) disable iff (reset)
      (!stage_in.zero && stage_in.mant[MAN_W+2])
      |=> (result.exp != '0 && result.exp != '1));

endmodule

`default_nettype wire

//--- verilog/fma_top.sv
// fma_top: five-stage pipelined binary32 fused multiply-add, result = a*b + c
`timescale 1ns/1ps
`default_nettype none

module fma_top (
   input  logic        clk,
   input  logic        reset,
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [31:0] c,
   output logic [31:0] result
);

   fma_pkg::unpack_t s1_unpack;
   fma_pkg::prod_t   s2_prod;
   fma_pkg::sum_t    s3_sum;
   fma_pkg::norm_t   s4_norm;

   fma_unpack i_unpack (
      .clk       (clk),
      .reset     (reset),
      .a         (a),
      .b         (b),
      .c         (c),
      .stage_out (s1_unpack)
   );

   fma_mul_align i_mul_align (
      .clk       (clk),
      .reset     (reset),
      .stage_in  (s1_unpack),
      .stage_out (s2_prod)
   );

   fma_add i_add (
      .clk       (clk),
      .reset     (reset),
      .stage_in  (s2_prod),
      .stage_out (s3_sum)
   );

   fma_normalize i_normalize (
      .clk       (clk),
      .reset     (reset),
      .stage_in  (s3_sum),
      .stage_out (s4_norm)
   );

   // registered inside the round stage
   fma_round i_round (
      .clk      (clk),
      .reset    (reset),
      .stage_in (s4_norm),
      .result   (result)
   );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// tb_clock_gen: testbench clock of 4 ns period and a synchronous reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD = 2,   // ns
   parameter int RST_CYCLES  = 4
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      reset <= 1'b0;   // released on the edge, like any other input
   end

endmodule

`default_nettype wire

//--- verif/fma_tb.sv
// fma_tb: directed and random binary32 fma operations checked against an exact reference
`timescale 1ns/1ps
`default_nettype none
`include "fma_cfg.svh"

module fma_tb;

   localparam int RST_CYCLES = 4;
   localparam int N_TESTS    = 400;
   localparam int N_DIRECTED = 24;
   localparam int DIR_EVERY  = 4;   // one directed slot in four
   localparam int TOTAL      = RST_CYCLES + N_TESTS;
   localparam int TIMEOUT    = 2 * (N_TESTS + `FMA_LATENCY + RST_CYCLES);

   typedef struct packed {
      fma_pkg::fp32_t a;
      fma_pkg::fp32_t b;
      fma_pkg::fp32_t c;
      fma_pkg::fp32_t want;
   } op_t;

   logic           clk;
   logic           reset;
   fma_pkg::fp32_t a;
   fma_pkg::fp32_t b;
   fma_pkg::fp32_t c;
   fma_pkg::fp32_t result;
   op_t            exp_q[$];
   int             seed;
   int             cycles = 0;

   tb_clock_gen #(.RST_CYCLES(RST_CYCLES)) i_clk_gen (.clk(clk), .reset(reset));

   fma_top i_fma_top (
      .clk    (clk),
      .reset  (reset),
      .a      (a),
      .b      (b),
      .c      (c),
      .result (result)
   );

   // exact a*b + c as a scaled integer, then one rounding to nearest even
   function automatic fma_pkg::fp32_t ref_fma(input fma_pkg::fp32_t fa,
                                              input fma_pkg::fp32_t fb,
                                              input fma_pkg::fp32_t fc);
      logic signed [255:0] acc;
      logic [255:0]        term;
      logic [255:0]        mag;
      logic [255:0]        rem;
      logic [255:0]        half;
      logic [47:0]         pm;
      logic [24:0]         mant;
      logic                p_zero;
      logic                p_sign;
      int                  pe;
      int                  ce;
      int                  base;
      int                  p;
      int                  sh;
      int                  e;
      fma_pkg::fp32_t      r;
      p_zero = (fa.exp == '0) || (fb.exp == '0);
      p_sign = fa.sign ^ fb.sign;
      pm     = 48'({1'b1, fa.frac}) * 48'({1'b1, fb.frac});
      pe     = int'(fa.exp) + int'(fb.exp) - 2*`FMA_BIAS - 46;   // weight of pm bit 0
      ce     = int'(fc.exp) - `FMA_BIAS - 23;
      if (p_zero)
         base = ce;
      else if (fc.exp == '0)
         base = pe;
      else
         base = (pe < ce) ? pe : ce;
      acc = '0;
      if (!p_zero) begin
         term = 256'(pm) << (pe - base);
         acc  = p_sign ? acc - term : acc + term;
      end
      if (fc.exp != '0) begin
         term = 256'({1'b1, fc.frac}) << (ce - base);
         acc  = fc.sign ? acc - term : acc + term;
      end
      r = '0;
      if (acc == 0) begin
         r.sign = p_sign & fc.sign;   // -0 only from two negative terms
         return r;
      end
      r.sign = acc[255];
      mag    = r.sign ? -acc : acc;
      p      = 0;
      for (int i = 0; i < 256; i++)
         if (mag[i])
            p = i;
      if (p > 23) begin
         sh   = p - 23;
         mant = 25'(mag >> sh);
         rem  = mag & ((256'd1 << sh) - 256'd1);
         half = 256'd1 << (sh - 1);
         if (rem > half || (rem == half && mant[0]))
            mant = mant + 25'd1;
      end else begin
         mant = 25'(mag << (23 - p));
      end
      e = base + p + `FMA_BIAS;
      if (mant[24]) begin   // rounding reached the next power of two
         mant = mant >> 1;
         e    = e + 1;
      end
      r.exp  = 8'(e);
      r.frac = mant[22:0];
      return r;
   endfunction

   task automatic check_fp32(input fma_pkg::fp32_t got, input fma_pkg::fp32_t want,
                             input fma_pkg::fp32_t op_a, input fma_pkg::fp32_t op_b,
                             input fma_pkg::fp32_t op_c);
      if (got !== want) begin
         $display("ERR %0t: result mismatch a=%h b=%h c=%h got=%h expected=%h",
                  $time, op_a, op_b, op_c, got, want);
         $display("TEST FAILED");
         $fatal(1, "fma result mismatch");
      end
   endtask

   task automatic directed_case(input int idx, output fma_pkg::fp32_t da,
                                output fma_pkg::fp32_t db, output fma_pkg::fp32_t dc);
      case (idx)
         0:  {da, db, dc} = {32'h3F800000, 32'h3F800000, 32'h3F800000}; // 1*1+1 carries out
         1:  {da, db, dc} = {32'h3FC00000, 32'h3FC00000, 32'h41000000}; // addend above
         2:  {da, db, dc} = {32'h40400000, 32'h40000000, 32'h3E800000}; // addend below
         3:  {da, db, dc} = {32'h3FE00000, 32'h3FE00000, 32'h40000000}; // equal exponents
         4:  {da, db, dc} = {32'h3F800001, 32'h3F800001, 32'hBF800002}; // cancel to 2^-46
         5:  {da, db, dc} = {32'h40000000, 32'h40400000, 32'hC0C00000}; // exact zero
         6:  {da, db, dc} = {32'hC0000000, 32'h40400000, 32'h40C00000};
         7:  {da, db, dc} = {32'h80000000, 32'h3F800000, 32'h80000000}; // -0 plus -0
         8:  {da, db, dc} = {32'h00000000, 32'hBF800000, 32'h00000000};
         9:  {da, db, dc} = {32'h3F800000, 32'h3F800000, 32'h33800000}; // tie stays even
         10: {da, db, dc} = {32'h3F800000, 32'h3F800000, 32'h34400000}; // tie rounds up
         11: {da, db, dc} = {32'h3F800000, 32'h3F800000, 32'h33800001}; // just above tie
         12: {da, db, dc} = {32'h3F800000, 32'h3F800000, 32'h337FFFFF}; // just below tie
         13: {da, db, dc} = {32'h3F800000, 32'h3FFFFFFF, 32'h33800000}; // tie into 2.0
         14: {da, db, dc} = {32'h3FC00000, 32'h3F800003, 32'h21800000}; // sticky breaks tie up
         15: {da, db, dc} = {32'h3FC00000, 32'h3F800001, 32'hA1800000}; // sticky drops below tie
         16: {da, db, dc} = {32'h3FC00000, 32'h3FC00000, 32'h53800000}; // addend mode
         17: {da, db, dc} = {32'h3FC00000, 32'h3FC00000, 32'hD3800000};
         18: {da, db, dc} = {32'h41000000, 32'h41000000, 32'h4E800000}; // 2^30 + 64 tie
         19: {da, db, dc} = {32'h00000000, 32'h40400000, 32'h3FA00000}; // a zero
         20: {da, db, dc} = {32'h40A00000, 32'h00000000, 32'hC0F00000}; // b zero
         21: {da, db, dc} = {32'h3F800001, 32'h3F800001, 32'h00000000}; // c zero
         22: {da, db, dc} = {32'hC0400000, 32'h3F8CCCCD, 32'h00000000};
         default: {da, db, dc} = {32'h3F800001, 32'h3F7FFFFF, 32'hBF800000};
      endcase
   endtask

   // product exponent mid range and c within 60 binades of it or zero
   task automatic random_case(output fma_pkg::fp32_t ra, output fma_pkg::fp32_t rb,
                              output fma_pkg::fp32_t rc);
      int pe;
      ra     = fma_pkg::fp32_t'($random(seed));
      ra.exp = 8'(100 + {$random(seed)} % 55);
      rb     = fma_pkg::fp32_t'($random(seed));
      rb.exp = 8'(100 + {$random(seed)} % 55);
      pe     = int'(ra.exp) + int'(rb.exp) - `FMA_BIAS;
      rc     = fma_pkg::fp32_t'($random(seed));
      if ({$random(seed)} % 8 == 0) begin
         rc.exp  = '0;
         rc.frac = '0;
      end else begin
         rc.exp = 8'(pe - 60 + int'({$random(seed)} % 121));
      end
   endtask

   initial begin : drive
      fma_pkg::fp32_t na;
      fma_pkg::fp32_t nb;
      fma_pkg::fp32_t nc;
      int             dir_idx;
      seed    = 66;
      dir_idx = 0;
      a = '0;
      b = '0;
      c = '0;
      repeat (RST_CYCLES) begin
         @(posedge clk);
         exp_q.push_back('0);   // zero operands through reset
      end
      for (int i = 0; i < N_TESTS; i++) begin
         if (i % DIR_EVERY == 0 && dir_idx < N_DIRECTED) begin
            directed_case(dir_idx, na, nb, nc);
            dir_idx++;
         end else begin
            random_case(na, nb, nc);
         end
         @(posedge clk);
         a <= na;
         b <= nb;
         c <= nc;
         exp_q.push_back({na, nb, nc, ref_fma(na, nb, nc)});
      end
      @(posedge clk);
      a <= '0;
      b <= '0;
      c <= '0;
   end

   // sampled on the falling edge half a cycle after the result register moves
   initial begin : compare
      op_t op;
      int  checked;
      checked = 0;
      repeat (`FMA_LATENCY) begin
         @(negedge clk);
         check_fp32(result, '0, '0, '0, '0);   // reset and empty pipe
      end
      while (checked < TOTAL) begin
         @(negedge clk);
         if (exp_q.size() == 0) begin
            $display("no expected value was queued for the result at %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "expected-value queue ran empty");
         end else begin
            op = exp_q.pop_front();
            check_fp32(result, op.want, op.a, op.b, op.c);
            checked++;
         end
      end
      if (exp_q.size() == 0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("%0d expected values were never compared", exp_q.size());
         $display("TEST FAILED");
         $fatal(1, "unchecked results left in the queue");
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("the run did not finish within %0d cycles", TIMEOUT);
         $display("TEST FAILED");
         $fatal(1, "simulation timeout");
      end
   end

endmodule

`default_nettype wire

//--- fma_top.f
+incdir+verilog
verilog/fma_pkg.sv
verilog/booth_pp_gen.sv
verilog/fma_unpack.sv
verilog/fma_mul_align.sv
verilog/fma_add.sv
verilog/fma_normalize.sv
verilog/fma_round.sv
verilog/fma_top.sv
verif/tb_clock_gen.sv
verif/fma_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fma testbench with verilator and run it
# exit status follows the simulation

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fma_sim

verilator --binary --timing --assert -Wno-fatal \
   --top-module fma_tb \
   -f fma_top.f \
   --Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0
